// File: hw/axi_pkg.sv
package axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Byte address on the system bus
  typedef logic [31:0] axi_addr_t;

  // One 4-byte data beat
  typedef logic [31:0] axi_data_t;

  // Burst length field, beats minus one
  typedef logic [7:0] axi_len_t;

  //////////////////////////////////////////////////////////////////////
  // Burst shapes
  //////////////////////////////////////////////////////////////////////

  // Data bursts are always 16 beats of 4 bytes, INCR
  localparam int BURST_BEATS = 16;
  localparam int BURST_BYTES = 64;

  // A descriptor line is two beats, low word first
  localparam int DESC_BEATS = 2;

  //////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////

  // Read address channel
  typedef struct packed {
    axi_addr_t addr;
    axi_len_t  len;
  } axi_rd_addr_t;

  // Read data channel
  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_rd_data_t;

  // Write data channel
  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_wr_data_t;

endpackage

// File: hw/adma_pkg.sv
package adma_pkg;

  //////////////////////////////////////////////////////////////////////
  // ADMA2 descriptor line
  //////////////////////////////////////////////////////////////////////

  // Action field, bits 5:4 of the descriptor
  typedef enum logic [1:0] {
    ACT_NOP  = 2'b00,
    ACT_RSV  = 2'b01,  // handled like nop
    ACT_TRAN = 2'b10,
    ACT_LINK = 2'b11
  } desc_act_t;

  // 64-bit line, address in the upper word
  typedef struct packed {
    axi_pkg::axi_addr_t addr;
    logic [15:0]        len;
    logic [9:0]         rsvd;
    desc_act_t          act;
    logic               rsvd_b3;
    logic               intr;
    logic               is_end;
    logic               valid;
  } desc_t;

  // Size of one line in system memory
  localparam int DESC_BYTES = 8;

  // ADMA2 states as in the host controller spec
  typedef enum logic [1:0] {
    ST_STOP,
    ST_FDS,
    ST_CADR,
    ST_TFR
  } adma_state_t;

  //////////////////////////////////////////////////////////////////////
  // Commands to the bus movers
  //////////////////////////////////////////////////////////////////////

  // Byte count, wide enough for 65536
  typedef logic [16:0] xfer_len_t;

  typedef enum logic {
    MOVE_DESC,
    MOVE_DATA
  } move_kind_t;

  typedef struct packed {
    axi_pkg::axi_addr_t addr;
    xfer_len_t          len;
    move_kind_t         kind;
  } move_cmd_t;

endpackage

// File: hw/adma_descriptor_engine.sv
module adma_descriptor_engine (
  input  logic               clock,
  input  logic               reset,
  input  logic               cmd_done,
  input  logic               dma_enable,
  input  logic               data_present,
  input  logic               card_to_mem,
  input  logic               blk_gap_req,
  input  logic               irq_clear,
  input  axi_pkg::axi_addr_t desc_pointer_in,
  input  logic               read_done,
  input  logic               write_done,
  input  adma_pkg::desc_t    fetched_desc,
  output adma_pkg::move_cmd_t move_cmd,
  output logic               read_start,
  output logic               write_start,
  output logic               irq_xfer_done,
  output logic               irq_adma_error,
  output logic               busy
);

  import adma_pkg::*;
  import axi_pkg::*;

  adma_state_t state;
  desc_t       desc_q;
  axi_addr_t   desc_ptr;
  xfer_len_t   data_len;
  logic        dir_c2m;
  logic        launch;
  logic        data_done;
  logic        xfer_fin;
  logic        fetch_pulse;
  logic        rd_pulse;
  logic        wr_pulse;

  // Start condition seen straight from the command path
  assign launch = (state == ST_STOP) && cmd_done && dma_enable && data_present;

  assign data_done = dir_c2m ? write_done : read_done;

  // Zero length field stands for 64 KiB
  assign data_len = (desc_q.len == 16'h0000) ? 17'h10000 : {1'b0, desc_q.len};

  assign read_start  = launch || fetch_pulse || rd_pulse;
  assign write_start = wr_pulse;
  assign busy        = (state != ST_STOP);

  //////////////////////////////////////////////////////////////////////
  // Mover command, follows the state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    move_cmd.addr = desc_ptr;
    move_cmd.len  = xfer_len_t'(DESC_BYTES);
    move_cmd.kind = MOVE_DESC;
    if (state == ST_STOP) begin
      // First fetch goes out in the launch cycle itself
      move_cmd.addr = desc_pointer_in;
    end else if (state == ST_TFR) begin
      move_cmd.addr = desc_q.addr;
      move_cmd.len  = data_len;
      move_cmd.kind = MOVE_DATA;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ADMA2 FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= ST_STOP;
      xfer_fin       <= 1'b0;
      fetch_pulse    <= 1'b0;
      rd_pulse       <= 1'b0;
      wr_pulse       <= 1'b0;
      irq_xfer_done  <= 1'b0;
      irq_adma_error <= 1'b0;
    end else begin
      fetch_pulse <= 1'b0;
      rd_pulse    <= 1'b0;
      wr_pulse    <= 1'b0;
      if (irq_clear) begin
        irq_xfer_done  <= 1'b0;
        irq_adma_error <= 1'b0;
      end
      case (state)
        ST_STOP: begin
          if (launch) begin
            state <= ST_FDS;
          end
        end
        ST_FDS: begin
          if (read_done) begin
            state <= ST_CADR;
          end
        end
        ST_CADR: begin
          if (!desc_q.valid) begin
            irq_adma_error <= 1'b1;
            state          <= ST_STOP;
          end else if (desc_q.act == ACT_TRAN) begin
            rd_pulse <= !dir_c2m;
            wr_pulse <= dir_c2m;
            xfer_fin <= 1'b0;
            state    <= ST_TFR;
          end else if (desc_q.is_end) begin
            irq_xfer_done <= 1'b1;
            state         <= ST_STOP;
          end else begin
            fetch_pulse <= 1'b1;
            state       <= ST_FDS;
          end
        end
        ST_TFR: begin
          // One cycle after the mover reports, decide where to go
          if (xfer_fin) begin
            xfer_fin <= 1'b0;
            if (desc_q.is_end || blk_gap_req) begin
              irq_xfer_done <= 1'b1;
              state         <= ST_STOP;
            end else begin
              fetch_pulse <= 1'b1;
              state       <= ST_FDS;
            end
          end else if (data_done) begin
            xfer_fin <= 1'b1;
          end
        end
        default: begin
          state <= ST_STOP;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor pointer and current line
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (launch) begin
      desc_ptr <= desc_pointer_in;
      dir_c2m  <= card_to_mem;
    end
    if ((state == ST_FDS) && read_done) begin
      desc_q <= fetched_desc;
    end
    if ((state == ST_CADR) && desc_q.valid) begin
      if (desc_q.act == ACT_LINK) begin
        desc_ptr <= desc_q.addr;
      end else begin
        desc_ptr <= desc_ptr + axi_addr_t'(DESC_BYTES);
      end
    end
  end

endmodule

// File: hw/axi_burst_reader.sv
module axi_burst_reader (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 read_start,
  input  adma_pkg::move_cmd_t  move_cmd,
  input  logic                 arready,
  input  axi_pkg::axi_rd_data_t r,
  input  logic                 rvalid,
  input  logic                 card_full,
  output axi_pkg::axi_rd_addr_t ar,
  output logic                 arvalid,
  output logic                 rready,
  output logic                 card_wr_en,
  output axi_pkg::axi_data_t   card_wdata,
  output logic                 read_done,
  output adma_pkg::desc_t      fetched_desc
);

  import adma_pkg::*;
  import axi_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  rd_state_t  state;
  move_kind_t kind;
  xfer_len_t  remaining;
  logic       is_data;
  logic       beat;
  logic       last_burst;

  assign is_data = (kind == MOVE_DATA);

  // Card FIFO back-pressure only matters for data
  assign rready = (state == RD_DATA) && !(is_data && card_full);
  assign beat   = rvalid && rready;

  assign card_wr_en = beat && is_data;
  assign card_wdata = r.data;

  assign last_burst = !is_data || (remaining == xfer_len_t'(BURST_BYTES));

  //////////////////////////////////////////////////////////////////////
  // Burst sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state     <= RD_IDLE;
      arvalid   <= 1'b0;
      read_done <= 1'b0;
    end else begin
      read_done <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (read_start) begin
            arvalid <= 1'b1;
            state   <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            state   <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (beat && r.last) begin
            if (last_burst) begin
              read_done <= 1'b1;
              state     <= RD_IDLE;
            end else begin
              arvalid <= 1'b1;
              state   <= RD_ADDR;
            end
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address, remaining count and descriptor assembly
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if ((state == RD_IDLE) && read_start) begin
      ar.addr   <= move_cmd.addr;
      kind      <= move_cmd.kind;
      remaining <= move_cmd.len;
      if (move_cmd.kind == MOVE_DESC) begin
        ar.len <= axi_len_t'(DESC_BEATS - 1);
      end else begin
        ar.len <= axi_len_t'(BURST_BEATS - 1);
      end
    end
    if (beat) begin
      if (!is_data) begin
        // Shift in from the top so the first word lands low
        fetched_desc <= {r.data, fetched_desc[63:32]};
      end else if (r.last) begin
        ar.addr   <= ar.addr + axi_addr_t'(BURST_BYTES);
        remaining <= remaining - xfer_len_t'(BURST_BYTES);
      end
    end
  end

endmodule

// File: hw/axi_burst_writer.sv
module axi_burst_writer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  write_start,
  input  adma_pkg::move_cmd_t   move_cmd,
  input  logic                  awready,
  input  logic                  wready,
  input  logic                  card_empty,
  input  axi_pkg::axi_data_t    card_rdata,
  output axi_pkg::axi_addr_t    awaddr,
  output logic                  awvalid,
  output axi_pkg::axi_wr_data_t w,
  output logic                  wvalid,
  output logic                  card_rd_en,
  output logic                  write_done
);

  import adma_pkg::*;
  import axi_pkg::*;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_ADDR,
    WR_FILL,
    WR_LOAD,
    WR_DATA
  } wr_state_t;

  wr_state_t state;
  xfer_len_t remaining;
  axi_len_t  beat_idx;
  logic      w_beat;

  // Pop one word at a time, only when the FIFO has one
  assign card_rd_en = (state == WR_FILL) && !card_empty;

  assign w_beat = (state == WR_DATA) && wready;

  //////////////////////////////////////////////////////////////////////
  // Burst sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= WR_IDLE;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      write_done <= 1'b0;
    end else begin
      write_done <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (write_start) begin
            awvalid <= 1'b1;
            state   <= WR_ADDR;
          end
        end
        WR_ADDR: begin
          if (awready) begin
            awvalid <= 1'b0;
            state   <= WR_FILL;
          end
        end
        WR_FILL: begin
          if (!card_empty) begin
            state <= WR_LOAD;
          end
        end
        WR_LOAD: begin
          wvalid <= 1'b1;
          state  <= WR_DATA;
        end
        WR_DATA: begin
          if (wready) begin
            wvalid <= 1'b0;
            if (!w.last) begin
              state <= WR_FILL;
            end else if (remaining == xfer_len_t'(BURST_BYTES)) begin
              write_done <= 1'b1;
              state      <= WR_IDLE;
            end else begin
              awvalid <= 1'b1;
              state   <= WR_ADDR;
            end
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address, holding register and beat count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if ((state == WR_IDLE) && write_start) begin
      awaddr    <= move_cmd.addr;
      remaining <= move_cmd.len;
    end
    if ((state == WR_ADDR) && awready) begin
      beat_idx <= '0;
    end
    // Card data arrives the cycle after the pop
    if (state == WR_LOAD) begin
      w.data <= card_rdata;
      w.last <= (beat_idx == axi_len_t'(BURST_BEATS - 1));
    end
    if (w_beat) begin
      beat_idx <= beat_idx + 8'd1;
      if (w.last) begin
        awaddr    <= awaddr + axi_addr_t'(BURST_BYTES);
        remaining <= remaining - xfer_len_t'(BURST_BYTES);
      end
    end
  end

endmodule

// File: hw/sd_adma_top.sv
module sd_adma_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmd_done,
  input  logic                  dma_enable,
  input  logic                  data_present,
  input  logic                  card_to_mem,
  input  logic                  blk_gap_req,
  input  logic                  irq_clear,
  input  axi_pkg::axi_addr_t    desc_pointer_in,
  output logic                  irq_xfer_done,
  output logic                  irq_adma_error,
  output logic                  busy,
  // AXI read side
  output axi_pkg::axi_rd_addr_t ar,
  output logic                  arvalid,
  input  logic                  arready,
  input  axi_pkg::axi_rd_data_t r,
  input  logic                  rvalid,
  output logic                  rready,
  // AXI write side
  output axi_pkg::axi_addr_t    awaddr,
  output logic                  awvalid,
  input  logic                  awready,
  output axi_pkg::axi_wr_data_t w,
  output logic                  wvalid,
  input  logic                  wready,
  // Card FIFO ports
  input  logic                  card_full,
  output logic                  card_wr_en,
  output axi_pkg::axi_data_t    card_wdata,
  input  logic                  card_empty,
  output logic                  card_rd_en,
  input  axi_pkg::axi_data_t    card_rdata
);

  import adma_pkg::*;

  // Engine to mover handshake
  move_cmd_t move_cmd;
  logic      read_start;
  logic      write_start;
  logic      read_done;
  logic      write_done;
  desc_t     fetched_desc;

  adma_descriptor_engine u_engine (.*);

  axi_burst_reader u_reader (.*);

  axi_burst_writer u_writer (.*);

endmodule

// File: bench/axi_mem_model.sv
module axi_mem_model (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stalls,
  input  axi_pkg::axi_rd_addr_t ar,
  input  logic                  arvalid,
  output logic                  arready,
  output axi_pkg::axi_rd_data_t r,
  output logic                  rvalid,
  input  logic                  rready,
  input  axi_pkg::axi_addr_t    awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  axi_pkg::axi_wr_data_t w,
  input  logic                  wvalid,
  output logic                  wready,
  output logic                  card_full,
  output logic                  card_empty,
  input  logic                  card_rd_en,
  output axi_pkg::axi_data_t    card_rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;

  // 1 MiB of word storage
  localparam int MEM_WORDS = 1 << 18;

  axi_data_t   mem [MEM_WORDS];
  axi_data_t   card_src [$];
  axi_data_t   card_word;
  axi_addr_t   rd_addr;
  axi_addr_t   wr_addr;
  int unsigned rd_left;
  int unsigned wr_count = 0;

  // Background pattern, rotated address so every bit counts
  function automatic axi_data_t fill_word(input axi_addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic axi_data_t read_word(input axi_addr_t addr);
    return mem[addr[19:2]];
  endfunction

  function automatic void write_word(input axi_addr_t addr, input axi_data_t data);
    mem[addr[19:2]] = data;
  endfunction

  function automatic void push_card(input axi_data_t data);
    card_src.push_back(data);
  endfunction

  function automatic int card_left();
    return card_src.size();
  endfunction

  function automatic void clear_count();
    wr_count = 0;
  endfunction

  // One cycle in four is held off when stalls are on
  function automatic logic allow_beat();
    return !stalls || (($urandom % 4) != 0);
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(axi_addr_t'(i) << 2);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slave channels and card source FIFO
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (!reset) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      awready    <= 1'b0;
      wready     <= 1'b0;
      card_full  <= 1'b0;
      card_empty <= 1'b1;
      rd_left = 0;
    end else begin
      // Read burst bookkeeping
      if (rvalid && rready) begin
        rd_addr = rd_addr + 4;
        rd_left = rd_left - 1;
      end
      if (arvalid && arready) begin
        rd_addr = ar.addr;
        rd_left = ar.len + 1;
      end
      // A beat on offer stays put until taken
      if (!rvalid || rready) begin
        if ((rd_left != 0) && allow_beat()) begin
          rvalid <= 1'b1;
          r.data <= read_word(rd_addr);
          r.last <= (rd_left == 1);
        end else begin
          rvalid <= 1'b0;
        end
      end
      arready <= allow_beat();

      if (awvalid && awready) begin
        wr_addr = awaddr;
      end
      if (wvalid && wready) begin
        write_word(wr_addr, w.data);
        wr_addr  = wr_addr + 4;
        wr_count = wr_count + 1;
      end
      awready <= allow_beat();
      wready  <= allow_beat();

      // Card data shows up the cycle after the pop
      if (card_rd_en && (card_src.size() != 0)) begin
        card_word = card_src.pop_front();
        card_rdata <= card_word;
      end
      card_empty <= (card_src.size() == 0) || !allow_beat();
      card_full  <= stalls && (($urandom % 4) == 0);
    end
  end

endmodule

// File: bench/tb_sd_adma.sv
module tb_sd_adma;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;
  import adma_pkg::*;

  logic          clock;
  logic          reset;
  logic          cmd_done;
  logic          dma_enable;
  logic          data_present;
  logic          card_to_mem;
  logic          blk_gap_req;
  logic          irq_clear;
  axi_addr_t     desc_pointer_in;
  logic          irq_xfer_done;
  logic          irq_adma_error;
  logic          busy;
  axi_rd_addr_t  ar;
  logic          arvalid;
  logic          arready;
  axi_rd_data_t  r;
  logic          rvalid;
  logic          rready;
  axi_addr_t     awaddr;
  logic          awvalid;
  logic          awready;
  axi_wr_data_t  w;
  logic          wvalid;
  logic          wready;
  logic          card_full;
  logic          card_wr_en;
  axi_data_t     card_wdata;
  logic          card_empty;
  logic          card_rd_en;
  axi_data_t     card_rdata;
  logic          stalls;

  int unsigned   errors = 0;
  int unsigned   checks = 0;
  int unsigned   tests_run = 0;
  int unsigned   tests_failed = 0;
  int unsigned   cycles = 0;
  int unsigned   cycle_limit = 2000;
  int unsigned   w_beats = 0;
  int unsigned   seed_value;
  int unsigned   ref_descs;
  string         test_name = "reset";
  axi_addr_t     exp_addr [$];
  axi_data_t     exp_data [$];
  axi_data_t     exp_card [$];
  axi_data_t     card_exp;
  logic [15:0]   len_a;
  logic [15:0]   len_b;

  sd_adma_top UUT (.*);

  axi_mem_model mem_model (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles while test %s was running", cycles, test_name);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_word(input string name, input axi_data_t got, input axi_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Card stream checked word by word as it leaves the reader
  always @(posedge clock) begin
    if (card_wr_en) begin
      if (exp_card.size() == 0) begin
        $display("Unexpected card word %h at %0t in test %s", card_wdata, $time, test_name);
        errors++;
      end else begin
        card_exp = exp_card.pop_front();
        compare_word("card_wdata", card_wdata, card_exp);
      end
    end
  end

  // Write bursts carry last on their 16th beat
  always @(posedge clock) begin
    if (awvalid && awready) begin
      w_beats = 0;
    end
    if (wvalid && wready) begin
      check_flag("w.last", w.last, w_beats == BURST_BEATS - 1);
      w_beats = w_beats + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor tables and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic put_desc(input axi_addr_t at, input axi_addr_t target, input logic [15:0] len,
                          input desc_act_t act, input logic is_end, input logic valid);
    desc_t d;
    d        = '0;
    d.addr   = target;
    d.len    = len;
    d.act    = act;
    d.is_end = is_end;
    d.valid  = valid;
    mem_model.write_word(at, d[31:0]);
    mem_model.write_word(at + 4, d[63:32]);
  endtask

  // Walks the ADMA2 table and queues the data word addresses in order
  // Returns 1 for complete or 0 for error
  function automatic logic walk_table(input axi_addr_t start, input logic gap);
    axi_addr_t   ptr;
    desc_t       d;
    int unsigned nbytes;
    ptr = start;
    exp_addr.delete();
    ref_descs = 0;
    for (int step = 0; step < 64; step++) begin
      d = {mem_model.read_word(ptr + 4), mem_model.read_word(ptr)};
      ref_descs++;
      if (!d.valid) begin
        return 1'b0;
      end
      if (d.act == ACT_TRAN) begin
        nbytes = (d.len == 16'h0000) ? 65536 : d.len;
        for (int unsigned i = 0; i < nbytes; i = i + 4) begin
          exp_addr.push_back(d.addr + i);
        end
        if (d.is_end || gap) begin
          return 1'b1;
        end
        ptr = ptr + 8;
      end else begin
        ptr = (d.act == ACT_LINK) ? d.addr : ptr + 8;
        if (d.is_end) begin
          return 1'b1;
        end
      end
    end
    return 1'b0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One test from command-complete to interrupt clear
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input string name, input axi_addr_t ptr, input logic c2m,
                          input logic gap);
    logic        exp_done;
    int unsigned errors_before;
    axi_data_t   word;
    test_name     = name;
    errors_before = errors;
    exp_done      = walk_table(ptr, gap);
    exp_card.delete();
    exp_data.delete();
    for (int i = 0; i < exp_addr.size(); i++) begin
      if (c2m) begin
        word = $urandom;
        exp_data.push_back(word);
        mem_model.push_card(word);
      end else begin
        exp_card.push_back(mem_model.read_word(exp_addr[i]));
      end
    end
    cycle_limit = cycle_limit + 8 * (exp_addr.size() + 2 * ref_descs);
    mem_model.clear_count();

    @(posedge clock);
    desc_pointer_in <= ptr;
    card_to_mem     <= c2m;
    blk_gap_req     <= gap;
    dma_enable      <= 1'b1;
    data_present    <= 1'b1;
    cmd_done        <= 1'b1;
    @(posedge clock);
    cmd_done <= 1'b0;
    @(negedge clock);
    while (!(irq_xfer_done || irq_adma_error)) begin
      @(negedge clock);
    end

    check_flag("irq_xfer_done", irq_xfer_done, exp_done);
    check_flag("irq_adma_error", irq_adma_error, !exp_done);
    check_flag("busy", busy, 1'b0);
    if (exp_card.size() != 0) begin
      $display("Card port is missing %0d words in test %s", exp_card.size(), name);
      errors++;
    end
    if (c2m) begin
      for (int i = 0; i < exp_addr.size(); i++) begin
        compare_word("memory word", mem_model.read_word(exp_addr[i]), exp_data[i]);
      end
    end
    // Any write outside the target regions shows up in the count
    if (mem_model.wr_count != (c2m ? exp_addr.size() : 0)) begin
      $display("Test %s wrote %0d memory words where %0d were due", name,
               mem_model.wr_count, c2m ? exp_addr.size() : 0);
      errors++;
    end
    if (mem_model.card_left() != 0) begin
      $display("Card FIFO still holds %0d words after test %s", mem_model.card_left(), name);
      errors++;
    end

    @(posedge clock);
    irq_clear    <= 1'b1;
    blk_gap_req  <= 1'b0;
    data_present <= 1'b0;
    @(posedge clock);
    irq_clear <= 1'b0;
    @(negedge clock);
    check_flag("irq_xfer_done", irq_xfer_done, 1'b0);
    check_flag("irq_adma_error", irq_adma_error, 1'b0);
    check_flag("busy", busy, 1'b0);

    tests_run++;
    if (errors == errors_before) begin
      $display("Test %0d %s passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s failed with %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  initial begin
    seed_value      = $urandom(76711);
    reset           = 1'b0;
    cmd_done        = 1'b0;
    dma_enable      = 1'b0;
    data_present    = 1'b0;
    card_to_mem     = 1'b0;
    blk_gap_req     = 1'b0;
    irq_clear       = 1'b0;
    desc_pointer_in = '0;
    stalls          = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    repeat (2) @(posedge clock);

    put_desc(32'h0000_1000, 32'h0002_0000, 16'd256, ACT_TRAN, 1'b1, 1'b1);
    run_test("single_to_card", 32'h0000_1000, 1'b0, 1'b0);

    // Tran, nop, link, then tran with end behind the link
    put_desc(32'h0000_1100, 32'h0003_0000, 16'd128, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1108, 32'h0000_0000, 16'd0, ACT_NOP, 1'b0, 1'b1);
    put_desc(32'h0000_1110, 32'h0000_1200, 16'd0, ACT_LINK, 1'b0, 1'b1);
    put_desc(32'h0000_1200, 32'h0003_1000, 16'd192, ACT_TRAN, 1'b1, 1'b1);
    run_test("chain_to_memory", 32'h0000_1100, 1'b1, 1'b0);

    put_desc(32'h0000_1300, 32'h0004_0000, 16'd64, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1308, 32'h0004_1000, 16'd64, ACT_TRAN, 1'b1, 1'b0);
    run_test("invalid_second", 32'h0000_1300, 1'b0, 1'b0);

    put_desc(32'h0000_1400, 32'h0004_2000, 16'd128, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1408, 32'h0004_3000, 16'd128, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1410, 32'h0004_4000, 16'd128, ACT_TRAN, 1'b1, 1'b1);
    run_test("block_gap", 32'h0000_1400, 1'b0, 1'b1);

    @(posedge clock);
    stalls <= 1'b1;

    // Random lengths around a full 64 KiB descriptor
    len_a = 16'(64 * (1 + ($urandom % 16)));
    len_b = 16'(64 * (1 + ($urandom % 16)));
    put_desc(32'h0000_1500, 32'h0005_0000, len_a, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1508, 32'h0008_0000, 16'd0, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1510, 32'h0006_0000, len_b, ACT_TRAN, 1'b1, 1'b1);
    run_test("stalled_to_card", 32'h0000_1500, 1'b0, 1'b0);

    len_a = 16'(64 * (1 + ($urandom % 16)));
    len_b = 16'(64 * (1 + ($urandom % 16)));
    put_desc(32'h0000_1600, 32'h0007_0000, len_a, ACT_TRAN, 1'b0, 1'b1);
    put_desc(32'h0000_1608, 32'h0000_1700, 16'd0, ACT_LINK, 1'b0, 1'b1);
    put_desc(32'h0000_1700, 32'h0007_1000, len_b, ACT_TRAN, 1'b1, 1'b1);
    run_test("stalled_to_memory", 32'h0000_1600, 1'b1, 1'b0);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sd_adma.f
hw/axi_pkg.sv
hw/adma_pkg.sv
hw/adma_descriptor_engine.sv
hw/axi_burst_reader.sv
hw/axi_burst_writer.sv
hw/sd_adma_top.sv
bench/axi_mem_model.sv
bench/tb_sd_adma.sv
